//--- src.f
verilog/dnc_write_pkg.sv
verilog/dnc_sigmoid_pwl.sv
verilog/dnc_write_key.sv
verilog/dnc_erase_vector.sv
verilog/dnc_write_strength.sv
verilog/dnc_write_gates.sv
verilog/dnc_write_interface.sv
tb/dnc_write_clock.sv
tb/dnc_write_interface_tb.sv

//--- Makefile
# Verilator build and run of the DNC write interface testbench

TOP       ?= dnc_write_interface_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: TOP FILELIST BUILD_DIR VERILATOR SIM_FLAGS"

test:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tb/dnc_write_interface_tb.sv
//////////////////////////////
// DNC write interface testbench
// Random and corner stimulus, queue-fed
// reference model, concurrent checks
//////////////////////////////

`timescale 1ns/100ps

module dnc_write_interface_tb;

  //////////////////////////////
  // Test sizes
  //////////////////////////////

  localparam int RESET_CYCLES = 10;
  localparam int IDLE_GAP     = 4;
  localparam int MAX_W        = 16;
  localparam int MAX_GAP      = 3;
  localparam int NUM_VECTORS  = 8;
  localparam int NUM_CORNERS  = 8;
  localparam int NUM_BETA     = 10;
  // Worst case per phase with vectors and idle gaps
  localparam int STREAM_CYCLES = (NUM_VECTORS + 1) * (MAX_W * (MAX_GAP + 1) + 2 * IDLE_GAP);
  localparam int SCALAR_CYCLES = (NUM_BETA + 2) * (MAX_GAP + 4 + 3 * IDLE_GAP);
  localparam int CYCLE_LIMIT   =
    2 * (RESET_CYCLES + STREAM_CYCLES + SCALAR_CYCLES + 6 * IDLE_GAP) + 200;

  // One beta result in flight
  typedef struct packed {
    logic                   valid;
    dnc_write_pkg::dnc_fx_t value;
  } beta_slot_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic                       CLK;
  logic                       RST;
  logic                       start;
  dnc_write_pkg::dnc_size_t   size_w;
  dnc_write_pkg::dnc_size_t   size_plan;
  dnc_write_pkg::dnc_stream_t k_in;
  dnc_write_pkg::dnc_stream_t e_in;
  dnc_write_pkg::dnc_fx_t     beta_in;
  dnc_write_pkg::dnc_gates_t  gates_in;
  dnc_write_pkg::dnc_stream_t k_out;
  logic                       k_ready;
  dnc_write_pkg::dnc_stream_t e_out;
  logic                       e_ready;
  dnc_write_pkg::dnc_fx_t     beta_out;
  logic                       beta_ready;
  dnc_write_pkg::dnc_gates_t  gates_out;
  logic                       gates_ready;

  // Check targets for the coming rising edge
  dnc_write_pkg::dnc_stream_t exp_k_out;
  logic                       exp_k_ready;
  dnc_write_pkg::dnc_stream_t exp_e_out;
  logic                       exp_e_ready;
  dnc_write_pkg::dnc_fx_t     exp_beta_out;
  logic                       exp_beta_ready;
  dnc_write_pkg::dnc_gates_t  exp_gates_out;
  logic                       exp_gates_ready;
  // Model results for the inputs just driven
  dnc_write_pkg::dnc_stream_t nxt_k_out;
  logic                       nxt_k_ready;
  dnc_write_pkg::dnc_stream_t nxt_e_out;
  logic                       nxt_e_ready;
  dnc_write_pkg::dnc_fx_t     nxt_beta_out;
  logic                       nxt_beta_ready;
  dnc_write_pkg::dnc_gates_t  nxt_gates_out;
  logic                       nxt_gates_ready;

  // Vector progress as seen by the model
  logic        k_running;
  logic        e_running;
  int unsigned k_count;
  int unsigned e_count;
  beta_slot_t  beta_q[$];

  string       test_name;
  int unsigned cycle_count = 0;

  // Saturation corners beyond +-2.0 plus extremes
  dnc_write_pkg::dnc_fx_t corner_vals[$] = '{
    32'h0000_0000, 32'h0002_0000, 32'hFFFE_0000, 32'h0002_0001,
    32'hFFFD_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF
  };
  // Beta regions and their borders
  dnc_write_pkg::dnc_fx_t beta_cases[$] = '{
    32'hFFFD_0000, 32'hFFFF_0000, 32'hFFFF_0001, 32'hFFFF_8000, 32'h0000_0000,
    32'h0000_C000, 32'h0000_FFFF, 32'h0001_0000, 32'h0002_8000, 32'h0008_0000
  };

  //////////////////////////////
  // Clock and DUT
  //////////////////////////////

  dnc_write_clock u_clock (
    .CLK (CLK),
    .RST (RST)
  );

  dnc_write_interface DUT (
    .CLK         (CLK),
    .RST         (RST),
    .START       (start),
    .SIZE_W_IN   (size_w),
    .K_IN        (k_in),
    .E_IN        (e_in),
    .BETA_IN     (beta_in),
    .GATES_IN    (gates_in),
    .K_OUT       (k_out),
    .K_READY     (k_ready),
    .E_OUT       (e_out),
    .E_READY     (e_ready),
    .BETA_OUT    (beta_out),
    .BETA_READY  (beta_ready),
    .GATES_OUT   (gates_out),
    .GATES_READY (gates_ready)
  );

  //////////////////////////////
  // Reference arithmetic
  //////////////////////////////

  // 0.25 x + 0.5 clamped to [0, 1.0]
  function automatic dnc_write_pkg::dnc_fx_t sigmoid_ref(input dnc_write_pkg::dnc_fx_t x);
    longint t;
    t = (longint'(x) >>> 2) + 64'sd32768;
    if (t < 64'sd0) begin
      t = 64'sd0;
    end
    else if (t > 64'sd65536) begin
      t = 64'sd65536;
    end
    return dnc_write_pkg::dnc_fx_t'(t);
  endfunction

  // 1.0 + h(x) with the middle region truncated from Q32.32
  function automatic dnc_write_pkg::dnc_fx_t oneplus_ref(input dnc_write_pkg::dnc_fx_t x);
    longint xp1;
    longint h;
    xp1 = longint'(x) + 64'sd65536;
    if (longint'(x) <= -64'sd65536) begin
      h = 64'sd0;
    end
    else if (longint'(x) >= 64'sd65536) begin
      h = longint'(x);
    end
    else begin
      h = (xp1 * xp1) >>> 18;
    end
    return dnc_write_pkg::dnc_fx_t'(64'sd65536 + h);
  endfunction

  // Uniform in [-span, span)
  function automatic dnc_write_pkg::dnc_fx_t rand_fx(input int unsigned span);
    return dnc_write_pkg::dnc_fx_t'($urandom % (2 * span)) - dnc_write_pkg::dnc_fx_t'(span);
  endfunction

  function automatic dnc_write_pkg::dnc_gates_t random_gates();
    dnc_write_pkg::dnc_gates_t g;
    g.alloc = rand_fx(32'd262144);
    g.write = rand_fx(32'd262144);
    return g;
  endfunction

  function automatic dnc_write_pkg::dnc_stream_t stream_word(
    input logic                   en,
    input dnc_write_pkg::dnc_fx_t data
  );
    dnc_write_pkg::dnc_stream_t w;
    w.enable = en;
    w.data   = data;
    return w;
  endfunction

  //////////////////////////////
  // Failure report
  //////////////////////////////

  task automatic fail_value(input string what, input logic [64:0] expected,
                            input logic [64:0] actual);
    $display("Some tests failed");
    $display("Error: test %s, %s expected %0h actual %0h", test_name, what, expected, actual);
    $fatal(1, "Output mismatch");
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Counting stream takes START only when idle and gives READY on the W-th element
  task automatic model_stream(input logic start_v, input dnc_write_pkg::dnc_stream_t in_v,
                              input logic squash, inout logic running,
                              inout int unsigned count,
                              inout dnc_write_pkg::dnc_stream_t out_v, output logic ready_v);
    out_v.enable = 1'b0;
    ready_v      = 1'b0;
    if (!running) begin
      if (start_v) begin
        running = 1'b1;
        count   = 0;
      end
    end
    else if (in_v.enable) begin
      out_v.enable = 1'b1;
      out_v.data   = squash ? sigmoid_ref(in_v.data) : in_v.data;
      count        = count + 1;
      if (count == size_w) begin
        ready_v = 1'b1;
        running = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Retire old results, drive and model on one falling edge
  task automatic drive_cycle(input logic start_v, input dnc_write_pkg::dnc_stream_t k_v,
                             input dnc_write_pkg::dnc_stream_t e_v,
                             input dnc_write_pkg::dnc_fx_t beta_v,
                             input dnc_write_pkg::dnc_gates_t gates_v);
    beta_slot_t slot;
    @(negedge CLK);
    exp_k_out       = nxt_k_out;
    exp_k_ready     = nxt_k_ready;
    exp_e_out       = nxt_e_out;
    exp_e_ready     = nxt_e_ready;
    exp_beta_out    = nxt_beta_out;
    exp_beta_ready  = nxt_beta_ready;
    exp_gates_out   = nxt_gates_out;
    exp_gates_ready = nxt_gates_ready;
    start    = start_v;
    size_w   = size_plan;
    k_in     = k_v;
    e_in     = e_v;
    beta_in  = beta_v;
    gates_in = gates_v;
    model_stream(start_v, k_v, 1'b0, k_running, k_count, nxt_k_out, nxt_k_ready);
    model_stream(start_v, e_v, 1'b1, e_running, e_count, nxt_e_out, nxt_e_ready);
    // Beta lags one cycle more so the queue holds one extra slot
    slot.valid = start_v;
    slot.value = oneplus_ref(beta_v);
    beta_q.push_back(slot);
    slot = beta_q.pop_front();
    nxt_beta_ready = slot.valid;
    if (slot.valid) begin
      nxt_beta_out = slot.value;
    end
    nxt_gates_ready = start_v;
    if (start_v) begin
      nxt_gates_out.alloc = sigmoid_ref(gates_v.alloc);
      nxt_gates_out.write = sigmoid_ref(gates_v.write);
    end
  endtask

  // No START and no enables, only noise on data
  task automatic idle_cycle();
    drive_cycle(1'b0, stream_word(1'b0, rand_fx(32'h0100_0000)),
                stream_word(1'b0, rand_fx(32'h0100_0000)), rand_fx(32'd262144), random_gates());
  endtask

  // Enables with no vector running
  task automatic stray_enables(input int unsigned count);
    repeat (count) begin
      drive_cycle(1'b0, stream_word(1'b1, rand_fx(32'h0100_0000)),
                  stream_word(1'b1, rand_fx(32'd262144)), rand_fx(32'd262144), random_gates());
    end
  endtask

  task automatic start_vector(input dnc_write_pkg::dnc_size_t size,
                              input dnc_write_pkg::dnc_fx_t beta_v,
                              input dnc_write_pkg::dnc_gates_t gates_v);
    size_plan = size;
    drive_cycle(1'b1, stream_word(1'b0, '0), stream_word(1'b0, '0), beta_v, gates_v);
  endtask

  // Elements with random gaps and erase data from corners or random
  task automatic send_elements(input int unsigned count, input logic corners);
    int unsigned gap;
    int unsigned i;
    dnc_write_pkg::dnc_fx_t e_data;
    for (i = 0; i < count; i++) begin
      gap = $urandom % (MAX_GAP + 1);
      repeat (gap) idle_cycle();
      e_data = corners ? corner_vals[i % NUM_CORNERS] : rand_fx(32'd196608);
      drive_cycle(1'b0, stream_word(1'b1, rand_fx(32'h0100_0000)), stream_word(1'b1, e_data),
                  rand_fx(32'd262144), random_gates());
    end
  endtask

  task automatic wait_stream_ready();
    do begin
      idle_cycle();
    end while (!(k_ready && e_ready));
  endtask

  task automatic wait_beta_ready();
    do begin
      idle_cycle();
    end while (!beta_ready);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_k_out: assert property (@(posedge CLK) disable iff (RST) k_out == exp_k_out)
    else fail_value("K_OUT", 65'(exp_k_out), 65'($sampled(k_out)));
  a_k_ready: assert property (@(posedge CLK) disable iff (RST) k_ready == exp_k_ready)
    else fail_value("K_READY", 65'(exp_k_ready), 65'($sampled(k_ready)));
  a_e_out: assert property (@(posedge CLK) disable iff (RST) e_out == exp_e_out)
    else fail_value("E_OUT", 65'(exp_e_out), 65'($sampled(e_out)));
  a_e_ready: assert property (@(posedge CLK) disable iff (RST) e_ready == exp_e_ready)
    else fail_value("E_READY", 65'(exp_e_ready), 65'($sampled(e_ready)));
  a_beta_out: assert property (@(posedge CLK) disable iff (RST) beta_out == exp_beta_out)
    else fail_value("BETA_OUT", 65'(exp_beta_out), 65'($sampled(beta_out)));
  a_beta_ready: assert property (@(posedge CLK) disable iff (RST) beta_ready == exp_beta_ready)
    else fail_value("BETA_READY", 65'(exp_beta_ready), 65'($sampled(beta_ready)));
  a_gates_out: assert property (@(posedge CLK) disable iff (RST) gates_out == exp_gates_out)
    else fail_value("GATES_OUT", 65'(exp_gates_out), 65'($sampled(gates_out)));
  a_gates_ready: assert property (
    @(posedge CLK) disable iff (RST) gates_ready == exp_gates_ready
  ) else fail_value("GATES_READY", 65'(exp_gates_ready), 65'($sampled(gates_ready)));

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Some tests failed");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int          idx;
    dnc_write_pkg::dnc_gates_t gates_v;
    void'($urandom(32'hf379));
    test_name = "reset";
    start     = 1'b0;
    size_w    = 32'd1;
    size_plan = 32'd1;
    k_in      = '0;
    e_in      = '0;
    beta_in   = '0;
    gates_in  = '0;
    // Everything reads 0 out of reset
    exp_k_out       = '0;
    exp_k_ready     = 1'b0;
    exp_e_out       = '0;
    exp_e_ready     = 1'b0;
    exp_beta_out    = '0;
    exp_beta_ready  = 1'b0;
    exp_gates_out   = '0;
    exp_gates_ready = 1'b0;
    nxt_k_out       = '0;
    nxt_k_ready     = 1'b0;
    nxt_e_out       = '0;
    nxt_e_ready     = 1'b0;
    nxt_beta_out    = '0;
    nxt_beta_ready  = 1'b0;
    nxt_gates_out   = '0;
    nxt_gates_ready = 1'b0;
    k_running = 1'b0;
    e_running = 1'b0;
    k_count   = 0;
    e_count   = 0;
    beta_q.push_back('0);
    wait (RST === 1'b0);
    repeat (IDLE_GAP) idle_cycle();

    test_name = "ignored enables before start";
    stray_enables(6);

    test_name = "key and erase streams";
    for (idx = 0; idx < NUM_VECTORS; idx++) begin
      start_vector(32'd1 + ($urandom % MAX_W), rand_fx(32'd262144), random_gates());
      send_elements(size_plan, 1'b0);
      wait_stream_ready();
      repeat (IDLE_GAP) idle_cycle();
    end

    test_name = "erase corners";
    start_vector(NUM_CORNERS, rand_fx(32'd262144), random_gates());
    send_elements(NUM_CORNERS, 1'b1);
    wait_stream_ready();

    // Each START also opens a one-element vector
    test_name = "write strength and gates";
    for (idx = 0; idx < NUM_BETA; idx++) begin
      gates_v.alloc = corner_vals[idx % NUM_CORNERS];
      gates_v.write = corner_vals[(idx + 3) % NUM_CORNERS];
      start_vector(32'd1, beta_cases[idx], gates_v);
      wait_beta_ready();
      send_elements(1, 1'b0);
      wait_stream_ready();
    end

    // Second START lands while the streams are busy
    test_name = "back-to-back starts";
    start_vector(32'd2, beta_cases[2], random_gates());
    start_vector(32'd2, beta_cases[5], random_gates());
    wait_beta_ready();
    idle_cycle();
    send_elements(2, 1'b0);
    wait_stream_ready();

    test_name = "ignored enables after vectors";
    stray_enables(6);
    repeat (IDLE_GAP) idle_cycle();

    $display("All tests passed");
    $finish;
  end

endmodule

//--- tb/dnc_write_clock.sv
//////////////////////////////
// Testbench clock and reset
// 40 ns clock, reset for 10 cycles
//////////////////////////////

`timescale 1ns/100ps

module dnc_write_clock (
  output logic CLK,
  output logic RST
);

  // Cycles with reset held
  localparam int RESET_CYCLES = 10;

  // Half period of 20 ns
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Release on a falling edge, away from the DUT's capture edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

//--- verilog/dnc_write_interface.sv
//////////////////////////////
// DNC write interface decoder
// Key, erase, write strength and
// gates from controller outputs
//////////////////////////////

`timescale 1ns/100ps

module dnc_write_interface (
  input  logic                       CLK,
  input  logic                       RST,
  // Controller side
  input  logic                       START,
  input  dnc_write_pkg::dnc_size_t   SIZE_W_IN,
  input  dnc_write_pkg::dnc_stream_t K_IN,
  input  dnc_write_pkg::dnc_stream_t E_IN,
  input  dnc_write_pkg::dnc_fx_t     BETA_IN,
  input  dnc_write_pkg::dnc_gates_t  GATES_IN,
  // Memory side
  output dnc_write_pkg::dnc_stream_t K_OUT,
  output logic                       K_READY,
  output dnc_write_pkg::dnc_stream_t E_OUT,
  output logic                       E_READY,
  output dnc_write_pkg::dnc_fx_t     BETA_OUT,
  output logic                       BETA_READY,
  output dnc_write_pkg::dnc_gates_t  GATES_OUT,
  output logic                       GATES_READY
);

  // Write key stream
  dnc_write_key u_write_key (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .READY     (K_READY),
    .SIZE_W_IN (SIZE_W_IN),
    .K_IN      (K_IN),
    .K_OUT     (K_OUT)
  );

  // Erase vector stream
  dnc_erase_vector u_erase_vector (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .READY     (E_READY),
    .SIZE_W_IN (SIZE_W_IN),
    .E_IN      (E_IN),
    .E_OUT     (E_OUT)
  );

  // Write strength, two cycles
  dnc_write_strength u_write_strength (
    .CLK      (CLK),
    .RST      (RST),
    .START    (START),
    .BETA_IN  (BETA_IN),
    .READY    (BETA_READY),
    .BETA_OUT (BETA_OUT)
  );

  // Allocation and write gates, one cycle
  dnc_write_gates u_write_gates (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .GATES_IN  (GATES_IN),
    .READY     (GATES_READY),
    .GATES_OUT (GATES_OUT)
  );

endmodule

//--- verilog/dnc_write_gates.sv
//////////////////////////////
// DNC write gates
// Hard sigmoid of allocation and
// write gate scalars, registered
//////////////////////////////

`timescale 1ns/100ps

module dnc_write_gates (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  dnc_write_pkg::dnc_gates_t GATES_IN,
  output logic                      READY,
  output dnc_write_pkg::dnc_gates_t GATES_OUT
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Both gates, squashed
  dnc_write_pkg::dnc_gates_t gates_sig;

  //////////////////////////////
  // Sigmoids
  //////////////////////////////

  // g^a(t) = sigmoid(g^a^(t))
  dnc_sigmoid_pwl u_alloc_sigmoid (
    .X (GATES_IN.alloc),
    .Y (gates_sig.alloc)
  );

  // g^w(t) = sigmoid(g^w^(t))
  dnc_sigmoid_pwl u_write_sigmoid (
    .X (GATES_IN.write),
    .Y (gates_sig.write)
  );

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY     <= 1'b0;
      GATES_OUT <= '0;
    end
    else begin
      // One-cycle pulse after START
      READY <= START;
      // Capture only on START, hold otherwise
      if (START) begin
        GATES_OUT <= gates_sig;
      end
    end
  end

endmodule

//--- verilog/dnc_write_strength.sv
//////////////////////////////
// DNC write strength
// beta = 1.0 + softplus(x), two-stage
// piecewise pipeline
//////////////////////////////

`timescale 1ns/100ps

module dnc_write_strength (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  dnc_write_pkg::dnc_fx_t BETA_IN,
  output logic                   READY,
  output dnc_write_pkg::dnc_fx_t BETA_OUT
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Stage 1, region flags and x + 1
  logic                   s1_valid;
  logic                   s1_low;
  logic                   s1_high;
  dnc_write_pkg::dnc_fx_t s1_xp1;

  // Stage 2 arithmetic, (x+1)^2 in Q32.32
  logic signed [2*dnc_write_pkg::DATA_SIZE-1:0] xp1_square;
  dnc_write_pkg::dnc_fx_t                       beta_next;

  //////////////////////////////
  // Stage 1
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end
    else begin
      s1_valid <= START;
    end
  end

  // Payload, qualified by s1_valid
  always_ff @(posedge CLK) begin
    s1_low  <= (BETA_IN <= -dnc_write_pkg::FX_ONE);
    s1_high <= (BETA_IN >= dnc_write_pkg::FX_ONE);
    s1_xp1  <= BETA_IN + dnc_write_pkg::FX_ONE;
  end

  //////////////////////////////
  // Stage 2
  //////////////////////////////

  assign xp1_square = s1_xp1 * s1_xp1;

  always_comb begin
    // Low region, h = 0
    if (s1_low) begin
      beta_next = dnc_write_pkg::FX_ONE;
    end
    // High region, 1 + x is already in s1_xp1
    else if (s1_high) begin
      beta_next = s1_xp1;
    end
    // Quadratic blend, /4 and Q32.32 to Q16.16 in one shift
    else begin
      beta_next = dnc_write_pkg::FX_ONE +
                  dnc_write_pkg::dnc_fx_t'(xp1_square >>> (dnc_write_pkg::FRAC_SIZE + 2));
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY    <= 1'b0;
      BETA_OUT <= '0;
    end
    else begin
      READY <= s1_valid;
      // Hold last beta between updates
      if (s1_valid) begin
        BETA_OUT <= beta_next;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // oneplus never drops below 1.0
  a_beta_floor: assert property (
    @(posedge CLK) disable iff (RST) READY |-> (BETA_OUT >= dnc_write_pkg::FX_ONE)
  );

endmodule

//--- verilog/dnc_erase_vector.sv
//////////////////////////////
// DNC erase vector
// Streams W elements through a
// hard sigmoid, READY on the last
//////////////////////////////

`timescale 1ns/100ps

module dnc_erase_vector (
  input  logic                       CLK,
  input  logic                       RST,
  // Control
  input  logic                       START,
  output logic                       READY,
  // Data
  input  dnc_write_pkg::dnc_size_t   SIZE_W_IN,
  input  dnc_write_pkg::dnc_stream_t E_IN,
  output dnc_write_pkg::dnc_stream_t E_OUT
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Counting FSM
  dnc_write_pkg::dnc_loop_state_t erase_fsm;

  // Element index, 0 to W-1
  dnc_write_pkg::dnc_size_t index_loop;

  // Sigmoid of the current input element
  dnc_write_pkg::dnc_fx_t e_sig;

  //////////////////////////////
  // Sigmoid
  //////////////////////////////

  dnc_sigmoid_pwl u_erase_sigmoid (
    .X (E_IN.data),
    .Y (e_sig)
  );

  //////////////////////////////
  // Body
  //////////////////////////////

  // e(t) = sigmoid(e^(t)), element by element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      erase_fsm  <= dnc_write_pkg::STARTER_STATE;
      index_loop <= '0;
      READY      <= 1'b0;
      E_OUT      <= '0;
    end
    else begin
      READY        <= 1'b0;
      E_OUT.enable <= 1'b0;
      case (erase_fsm)
        dnc_write_pkg::STARTER_STATE: begin
          if (START) begin
            index_loop <= '0;
            erase_fsm  <= dnc_write_pkg::ENDER_STATE;
          end
        end
        dnc_write_pkg::ENDER_STATE: begin
          if (E_IN.enable) begin
            // Register the squashed element
            E_OUT.data   <= e_sig;
            E_OUT.enable <= 1'b1;
            if (index_loop == (SIZE_W_IN - 32'd1)) begin
              READY      <= 1'b1;
              index_loop <= '0;
              erase_fsm  <= dnc_write_pkg::STARTER_STATE;
            end
            else begin
              index_loop <= index_loop + 32'd1;
            end
          end
        end
        default: begin
          erase_fsm <= dnc_write_pkg::STARTER_STATE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Erase weights stay in [0, 1.0]
  a_erase_range: assert property (
    @(posedge CLK) disable iff (RST)
      E_OUT.enable |-> (E_OUT.data >= 0 && E_OUT.data <= dnc_write_pkg::FX_ONE)
  );

endmodule

//--- verilog/dnc_write_key.sv
//////////////////////////////
// DNC write key
// Streams W key elements through,
// READY with the last element
//////////////////////////////

`timescale 1ns/100ps

module dnc_write_key (
  input  logic                       CLK,
  input  logic                       RST,
  // Control
  input  logic                       START,
  output logic                       READY,
  // Data
  input  dnc_write_pkg::dnc_size_t   SIZE_W_IN,
  input  dnc_write_pkg::dnc_stream_t K_IN,
  output dnc_write_pkg::dnc_stream_t K_OUT
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Counting FSM
  dnc_write_pkg::dnc_loop_state_t key_fsm;

  // Element index, 0 to W-1
  dnc_write_pkg::dnc_size_t index_loop;

  //////////////////////////////
  // Body
  //////////////////////////////

  // k(t) = k^(t), one element per input strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      key_fsm    <= dnc_write_pkg::STARTER_STATE;
      index_loop <= '0;
      READY      <= 1'b0;
      K_OUT      <= '0;
    end
    else begin
      // Strobes are single-cycle by default
      READY        <= 1'b0;
      K_OUT.enable <= 1'b0;
      case (key_fsm)
        dnc_write_pkg::STARTER_STATE: begin
          // Wait for START, stray enables dropped
          if (START) begin
            index_loop <= '0;
            key_fsm    <= dnc_write_pkg::ENDER_STATE;
          end
        end
        dnc_write_pkg::ENDER_STATE: begin
          if (K_IN.enable) begin
            // Register element
            K_OUT.data   <= K_IN.data;
            K_OUT.enable <= 1'b1;
            // Last element closes the vector
            if (index_loop == (SIZE_W_IN - 32'd1)) begin
              READY      <= 1'b1;
              index_loop <= '0;
              key_fsm    <= dnc_write_pkg::STARTER_STATE;
            end
            else begin
              index_loop <= index_loop + 32'd1;
            end
          end
        end
        default: begin
          key_fsm <= dnc_write_pkg::STARTER_STATE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Every output element is backed by an input strobe one cycle before
  a_key_enable_source: assert property (
    @(posedge CLK) disable iff (RST) K_OUT.enable |-> $past(K_IN.enable)
  );

endmodule

//--- verilog/dnc_sigmoid_pwl.sv
//////////////////////////////
// Hard sigmoid evaluator
// y = clamp(x/4 + 0.5, 0, 1.0)
//////////////////////////////

`timescale 1ns/100ps

module dnc_sigmoid_pwl (
  input  dnc_write_pkg::dnc_fx_t X,
  output dnc_write_pkg::dnc_fx_t Y
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Slope 0.25 as arithmetic shift
  dnc_write_pkg::dnc_fx_t x_quarter;
  // Unclamped line
  dnc_write_pkg::dnc_fx_t line_sum;

  //////////////////////////////
  // Body
  //////////////////////////////

  // Shift keeps sign, so no overflow on the add
  assign x_quarter = X >>> 2;
  assign line_sum  = x_quarter + dnc_write_pkg::FX_HALF;

  always_comb begin
    // Lower saturation
    if (line_sum < 0) begin
      Y = '0;
    end
    // Upper saturation at 1.0
    else if (line_sum > dnc_write_pkg::FX_ONE) begin
      Y = dnc_write_pkg::FX_ONE;
    end
    // Linear region
    else begin
      Y = line_sum;
    end
  end

endmodule

//--- verilog/dnc_write_pkg.sv
//////////////////////////////
// DNC write interface package
// Q16.16 widths and constants, stream
// and gate structs, loop FSM states
//////////////////////////////

package dnc_write_pkg;

  //////////////////////////////
  // Fixed-point format
  //////////////////////////////

  // Full data word
  localparam int DATA_SIZE = 32;
  // Fraction bits of Q16.16
  localparam int FRAC_SIZE = 16;

  //////////////////////////////
  // Types
  //////////////////////////////

  // One signed Q16.16 value
  typedef logic signed [DATA_SIZE-1:0] dnc_fx_t;

  // Element count W
  typedef logic [DATA_SIZE-1:0] dnc_size_t;

  // Constants in Q16.16
  localparam dnc_fx_t FX_ONE  = dnc_fx_t'(1) <<< FRAC_SIZE;
  localparam dnc_fx_t FX_HALF = dnc_fx_t'(1) <<< (FRAC_SIZE - 1);

  // Element stream, enable strobe plus data word
  typedef struct packed {
    logic    enable;
    dnc_fx_t data;
  } dnc_stream_t;

  // Allocation gate and write gate
  typedef struct packed {
    dnc_fx_t alloc;
    dnc_fx_t write;
  } dnc_gates_t;

  // Counting FSM for key and erase streams
  typedef enum logic {
    STARTER_STATE = 1'b0,
    ENDER_STATE   = 1'b1
  } dnc_loop_state_t;

endpackage
